// File: logic/cfg_pkg.sv
package cfg_pkg;

  localparam int packet_width    = 32;  // one packet is one axi word
  localparam int id_width        = 8;   // node id field
  localparam int cfg_data_width  = 24;  // config data field
  localparam int axil_addr_width = 8;   // small register window
  localparam int axil_data_width = 32;

  localparam logic [axil_addr_width-1:0] addr_packet = 8'h00;  // packet word, starts a send
  localparam logic [axil_addr_width-1:0] addr_status = 8'h04;  // bit 0 is busy

  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  typedef struct packed {
    logic [id_width-1:0]       id;    // upper bits, target node
    logic [cfg_data_width-1:0] data;  // lower bits, register value
  } cfg_packet_t;

  // register file works on raw, serializer on the fields
  typedef union packed {
    logic [packet_width-1:0] raw;
    cfg_packet_t             fields;
  } cfg_word_u;

  typedef struct packed {
    logic valid;     // a bit is on the link this cycle
    logic data_bit;  // serial bit, lsb of the packet first
    logic last;      // final bit of the frame
  } cfg_link_t;

  typedef struct packed {
    logic                       awvalid;
    logic [axil_addr_width-1:0] awaddr;
    logic                       wvalid;
    logic [axil_data_width-1:0] wdata;
    logic                       bready;
    logic                       arvalid;
    logic [axil_addr_width-1:0] araddr;
    logic                       rready;
  } axil_req_t;

  typedef struct packed {
    logic                       awready;
    logic                       wready;
    logic                       bvalid;
    logic [1:0]                 bresp;
    logic                       arready;
    logic                       rvalid;
    logic [axil_data_width-1:0] rdata;
    logic [1:0]                 rresp;
  } axil_rsp_t;

endpackage

// File: logic/cfg_axil_regs.sv
module cfg_axil_regs import cfg_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  axil_req_t axil_req,
  output axil_rsp_t axil_rsp,
  input  logic      busy,      // controller still sending
  output logic      send_req,  // one cycle pulse per packet write
  output cfg_word_u packet
);

  logic                       wr_accept;  // aw and w taken together
  logic                       rd_accept;
  logic                       wr_pend;    // write taken, response next cycle
  logic                       bvalid_q;
  logic [1:0]                 wr_resp;
  logic [1:0]                 wr_resp_q;  // stable until bready
  logic                       rvalid_q;
  logic [axil_data_width-1:0] rd_data;
  logic [1:0]                 rd_resp;
  logic [axil_data_width-1:0] rdata_q;
  logic [1:0]                 rresp_q;

  // both valids, controller idle and no response outstanding
  assign wr_accept = axil_req.awvalid & axil_req.wvalid & ~busy & ~wr_pend & ~bvalid_q;
  assign rd_accept = axil_req.arvalid & ~rvalid_q;  // reads ignore busy
  assign send_req  = wr_accept & (axil_req.awaddr == addr_packet);

  always_comb begin
    if ((axil_req.awaddr == addr_packet) || (axil_req.awaddr == addr_status)) begin
      wr_resp = resp_okay;  // status write is a no-op
    end else begin
      wr_resp = resp_slverr;
    end
  end

  always_comb begin
    rd_data = '0;  // zero data on bad address
    rd_resp = resp_okay;
    case (axil_req.araddr)
      addr_packet: rd_data = packet.raw;
      addr_status: rd_data = {{(axil_data_width-1){1'b0}}, busy};
      default:     rd_resp = resp_slverr;
    endcase
  end

  always_ff @(posedge clk) begin
    if (send_req) begin
      packet.raw <= axil_req.wdata;  // strobes ignored, full word
    end
    if (wr_accept) begin
      wr_resp_q <= wr_resp;
    end
    if (rd_accept) begin
      rdata_q <= rd_data;
      rresp_q <= rd_resp;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_pend  <= 1'b0;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      wr_pend <= wr_accept;  // bvalid one edge after the handshake
      if (wr_pend) begin
        bvalid_q <= 1'b1;
      end else if (bvalid_q && axil_req.bready) begin
        bvalid_q <= 1'b0;
      end
      if (rd_accept) begin
        rvalid_q <= 1'b1;
      end else if (rvalid_q && axil_req.rready) begin
        rvalid_q <= 1'b0;  // held until rready
      end
    end
  end

  always_comb begin
    axil_rsp.awready = wr_accept;
    axil_rsp.wready  = wr_accept;
    axil_rsp.bvalid  = bvalid_q;
    axil_rsp.bresp   = wr_resp_q;
    axil_rsp.arready = rd_accept;
    axil_rsp.rvalid  = rvalid_q;
    axil_rsp.rdata   = rdata_q;
    axil_rsp.rresp   = rresp_q;
  end

endmodule

// File: logic/cfg_ctrl_fsm.sv
module cfg_ctrl_fsm (
  input  logic clk,
  input  logic arst_n,
  input  logic send_req,
  input  logic last_bit,  // from bit counter
  output logic load,      // capture packet into serializer
  output logic shift,     // one link bit per cycle
  output logic run,       // keeps the bit counter going
  output logic busy
);

  localparam logic [1:0] st_idle  = 2'd0;
  localparam logic [1:0] st_load  = 2'd1;
  localparam logic [1:0] st_shift = 2'd2;

  logic [1:0] state;
  logic [1:0] state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:  if (send_req) state_nxt = st_load;
      st_load:  state_nxt = st_shift;  // single load cycle
      st_shift: if (last_bit) state_nxt = st_idle;
      default:  state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      busy  <= 1'b0;
    end else begin
      state <= state_nxt;
      // stays up one edge past shift so the node update lands first
      busy  <= (state_nxt != st_idle) | (state == st_shift);
    end
  end

  assign load  = (state == st_load);
  assign shift = (state == st_shift);
  assign run   = (state == st_shift);  // counts the same cycles as shift

endmodule

// File: logic/cfg_bit_counter.sv
module cfg_bit_counter #(
  parameter int frame_bits = 32  // bits per serial frame
) (
  input  logic clk,
  input  logic arst_n,
  input  logic run,
  output logic last_bit
);

  localparam int cnt_width = $clog2(frame_bits);

  logic [cnt_width-1:0] cnt;  // position of the bit now going out

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (!run || last_bit) begin
      cnt <= '0;  // ready for the next frame
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign last_bit = run & (cnt == cnt_width'(frame_bits - 1));

endmodule

// File: logic/cfg_serializer.sv
module cfg_serializer import cfg_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      load,
  input  logic      shift,
  input  logic      last_bit,
  input  cfg_word_u packet,
  output cfg_link_t link
);

  logic [packet_width-1:0] sreg;  // bit 0 goes out next

  always_ff @(posedge clk) begin
    if (load) begin
      sreg <= {packet.fields.id, packet.fields.data};  // data lsb leads the frame
    end else if (shift) begin
      sreg <= {1'b0, sreg[packet_width-1:1]};
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      link <= '0;
    end else begin
      link.valid    <= shift;
      link.data_bit <= shift & sreg[0];     // quiet line between frames
      link.last     <= shift & last_bit;  // tags the 32nd bit
    end
  end

endmodule

// File: logic/config_node.sv
module config_node import cfg_pkg::*; #(
  parameter int                    node_id     = 0,
  parameter int                    data_width  = 8,   // at most cfg_data_width
  parameter logic [data_width-1:0] reset_value = '0
) (
  input  logic                  clk,
  input  logic                  arst_n,
  input  cfg_link_t             link,  // broadcast, every node sees every frame
  output logic [data_width-1:0] data
);

  logic [packet_width-1:0] shift_q;  // frame assembled so far, newest bit on top
  cfg_packet_t             rx_word;
  logic                    hit;

  // full frame including the bit on the link right now
  assign rx_word = {link.data_bit, shift_q[packet_width-1:1]};
  assign hit     = link.valid & link.last & (rx_word.id == id_width'(node_id));

  always_ff @(posedge clk) begin
    if (link.valid) begin
      shift_q <= rx_word;  // lsb first, so shift toward bit 0
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      data <= reset_value;
    end else if (hit) begin
      data <= rx_word.data[data_width-1:0];  // narrow nodes keep the low bits
    end
  end

endmodule

// File: logic/cfg_top.sv
module cfg_top import cfg_pkg::*; (
  input  logic        clk,
  input  logic        arst_n,
  input  axil_req_t   axil_req,
  output axil_rsp_t   axil_rsp,
  output logic [7:0]  node_a_data,
  output logic [15:0] node_b_data,
  output logic [23:0] node_c_data
);

  logic      send_req;
  logic      busy;
  logic      load;
  logic      shift;
  logic      run;
  logic      last_bit;
  cfg_word_u packet;  // held word from the register file
  cfg_link_t link;    // serial broadcast

  cfg_axil_regs u_regs (
    .clk      (clk),
    .arst_n   (arst_n),
    .axil_req (axil_req),
    .axil_rsp (axil_rsp),
    .busy     (busy),
    .send_req (send_req),
    .packet   (packet)
  );

  cfg_ctrl_fsm u_fsm (
    .clk      (clk),
    .arst_n   (arst_n),
    .send_req (send_req),
    .last_bit (last_bit),
    .load     (load),
    .shift    (shift),
    .run      (run),
    .busy     (busy)
  );

  cfg_bit_counter #(.frame_bits(packet_width)) u_cnt (
    .clk      (clk),
    .arst_n   (arst_n),
    .run      (run),
    .last_bit (last_bit)
  );

  cfg_serializer u_ser (
    .clk      (clk),
    .arst_n   (arst_n),
    .load     (load),
    .shift    (shift),
    .last_bit (last_bit),
    .packet   (packet),
    .link     (link)
  );

  config_node #(.node_id(1), .data_width(8), .reset_value(8'h5A)) node_a (
    .clk    (clk),
    .arst_n (arst_n),
    .link   (link),
    .data   (node_a_data)
  );

  config_node #(.node_id(2), .data_width(16), .reset_value(16'h1234)) node_b (
    .clk    (clk),
    .arst_n (arst_n),
    .link   (link),
    .data   (node_b_data)
  );

  config_node #(.node_id(3), .data_width(24), .reset_value(24'h0)) node_c (
    .clk    (clk),
    .arst_n (arst_n),
    .link   (link),
    .data   (node_c_data)
  );

endmodule

// File: bench/config_node_bind_assert.sv
module config_node_bind_assert import cfg_pkg::*; #(
  parameter int                    node_id     = 0,
  parameter int                    data_width  = 8,
  parameter logic [data_width-1:0] reset_value = '0
) (
  input logic                  clk,
  input logic                  arst_n,
  input cfg_link_t             link,
  input logic [data_width-1:0] data
);
  timeunit 1ns;
  timeprecision 100ps;

  int                      fail_cnt;   // read by the testbench at the end
  logic [packet_width-1:0] shadow;     // own copy of the incoming frame
  logic [packet_width-1:0] frame;      // frame including the bit on the link now
  logic                    frame_hit;  // last bit of a frame addressed to this node
  logic [data_width-1:0]   frame_low;

  initial fail_cnt = 0;

  assign frame     = {link.data_bit, shadow[packet_width-1:1]};
  assign frame_hit = link.valid & link.last &
                     (frame[packet_width-1 -: id_width] == id_width'(node_id));
  assign frame_low = frame[data_width-1:0];

  always_ff @(posedge clk) begin
    if (link.valid) begin
      shadow <= frame;  // lsb first, shift toward bit 0
    end
  end

  // reset value in reset and on the first edge after release
  reset_value_held: assert property (@(posedge clk)
    (!arst_n || $rose(arst_n)) |-> (data == reset_value))
    else begin
      fail_cnt++;
      $error("node %0d output differs from its reset value", node_id);
    end

  // any change needs a last bit on the cycle before
  change_after_last: assert property (@(posedge clk) disable iff (!arst_n)
    !$stable(data) |-> $past(link.valid && link.last))
    else begin
      fail_cnt++;
      $error("node %0d output changed without a frame end", node_id);
    end

  matched_frame_loaded: assert property (@(posedge clk) disable iff (!arst_n)
    $past(frame_hit) |-> (data == $past(frame_low)))
    else begin
      fail_cnt++;
      $error("node %0d did not load the data of a matching frame", node_id);
    end

endmodule

// File: bench/cfg_tb.sv
module cfg_tb import cfg_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        arst_n;
  axil_req_t   axil_req;
  axil_rsp_t   axil_rsp;
  logic [7:0]  node_a_data;
  logic [15:0] node_b_data;
  logic [23:0] node_c_data;
  logic [7:0]  exp_a;  // model of the node registers
  logic [15:0] exp_b;
  logic [23:0] exp_c;
  integer      seed;
  int          chk_fails;

  cfg_top DUT (
    .clk         (clk),
    .arst_n      (arst_n),
    .axil_req    (axil_req),
    .axil_rsp    (axil_rsp),
    .node_a_data (node_a_data),
    .node_b_data (node_b_data),
    .node_c_data (node_c_data)
  );

  bind config_node config_node_bind_assert #(
    .node_id     (node_id),
    .data_width  (data_width),
    .reset_value (reset_value)
  ) node_chk (
    .clk    (clk),
    .arst_n (arst_n),
    .link   (link),
    .data   (data)
  );

  always #4 clk = ~clk;  // 8 ns period

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    assert (got === exp) else
      stop_run($sformatf("Error at %0d ns: %s is %h, expected %h", $time, what, got, exp));
  endtask

  function automatic bit nodes_match();
    return (node_a_data === exp_a) && (node_b_data === exp_b) && (node_c_data === exp_c);
  endfunction

  task automatic check_nodes(input string what);
    assert (nodes_match()) else
      stop_run($sformatf("Error at %0d ns: %s, nodes %h %h %h, expected %h %h %h", $time,
                         what, node_a_data, node_b_data, node_c_data, exp_a, exp_b, exp_c));
  endtask

  // a node loads the low bits of the data field when the id matches
  task automatic model_packet(input logic [31:0] word);
    case (word[31:24])
      8'd1:    exp_a = word[7:0];
      8'd2:    exp_b = word[15:0];
      8'd3:    exp_c = word[23:0];
      default: exp_a = exp_a;  // no node has this id
    endcase
  endtask

  // called and returns 1 ns after a rising edge
  task automatic axil_write(input logic [7:0] addr, input logic [31:0] word,
                            output logic [1:0] bresp, output int waits);
    int n;
    waits = 0;
    n = 0;
    axil_req.awaddr  = addr;
    axil_req.wdata   = word;
    axil_req.awvalid = 1'b1;
    axil_req.wvalid  = 1'b1;
    @(negedge clk);
    while (!(axil_rsp.awready && axil_rsp.wready)) begin  // stalled while busy
      waits++;
      if (waits > 100) stop_run("timeout while waiting for the write handshake");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    axil_req.awvalid = 1'b0;
    axil_req.wvalid  = 1'b0;
    axil_req.bready  = 1'b1;
    @(negedge clk);
    while (!axil_rsp.bvalid) begin
      n++;
      if (n > 10) stop_run("timeout while waiting for the write response");
      @(negedge clk);
    end
    bresp = axil_rsp.bresp;
    @(posedge clk);
    #1;
    axil_req.bready = 1'b0;
  endtask

  task automatic axil_read(input logic [7:0] addr, output logic [31:0] word,
                           output logic [1:0] rresp);
    int n;
    n = 0;
    axil_req.araddr  = addr;
    axil_req.arvalid = 1'b1;
    @(negedge clk);
    while (!axil_rsp.arready) begin
      n++;
      if (n > 20) stop_run("timeout while waiting for the read address handshake");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
    axil_req.arvalid = 1'b0;
    axil_req.rready  = 1'b1;
    n = 0;
    @(negedge clk);
    while (!axil_rsp.rvalid) begin
      n++;
      if (n > 10) stop_run("timeout while waiting for the read data");
      @(negedge clk);
    end
    word  = axil_rsp.rdata;
    rresp = axil_rsp.rresp;
    @(posedge clk);
    #1;
    axil_req.rready = 1'b0;
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    logic [1:0]  r;
    int          polls;
    polls = 0;
    axil_read(addr_status, st, r);
    while (st[0]) begin
      polls++;
      if (polls > 40) stop_run("timeout while waiting for the controller to go idle");
      axil_read(addr_status, st, r);
    end
  endtask

  task automatic wait_nodes_match();
    int n;
    n = 0;
    @(negedge clk);
    while (!nodes_match()) begin
      n++;
      if (n > 40) stop_run("node outputs did not reach their new values within 40 cycles");
      @(negedge clk);
    end
    @(posedge clk);
    #1;
  endtask

  task automatic send_packet(input logic [7:0] id, input logic [23:0] value, output int waits);
    logic [1:0] r;
    axil_write(addr_packet, {id, value}, r, waits);
    check_eq(32'(r), 32'(resp_okay), "bresp of packet write");
    model_packet({id, value});
  endtask

  task automatic test_reset_values();
    logic [31:0] st;
    logic [1:0]  r;
    check_nodes("reset values");
    check_eq(32'(axil_rsp.bvalid), 32'd0, "bvalid after reset");
    check_eq(32'(axil_rsp.rvalid), 32'd0, "rvalid after reset");
    axil_read(addr_status, st, r);
    check_eq(st, 32'd0, "status after reset");
    check_eq(32'(r), 32'(resp_okay), "rresp of status read");
  endtask

  task automatic test_each_node();
    logic [23:0] values [3] = '{24'hA1B2C3, 24'hD4E5F6, 24'h13579B};
    logic [31:0] rd;
    logic [1:0]  r;
    int          waits;
    for (int i = 1; i <= 3; i++) begin
      send_packet(8'(i), values[i-1], waits);
      wait_nodes_match();  // only the addressed node moves
      wait_idle();
      check_nodes("single node update");
      axil_read(addr_packet, rd, r);
      check_eq(rd, {8'(i), values[i-1]}, "packet read back");
      check_eq(32'(r), 32'(resp_okay), "rresp of packet read");
    end
  endtask

  task automatic test_unmatched_id();
    int waits;
    send_packet(8'd7, 24'hFFFFFF, waits);
    wait_idle();
    check_nodes("packet for id 7");
  endtask

  task automatic test_back_to_back();
    logic [31:0] st;
    logic [1:0]  r;
    int          waits;
    send_packet(8'd1, 24'h00003C, waits);
    axil_read(addr_status, st, r);
    check_eq(st, 32'd1, "status during first packet");
    send_packet(8'd2, 24'h00BEEF, waits);
    assert (waits > 0) else stop_run("the second write was accepted while the link was busy");
    wait_idle();
    check_nodes("back to back packets");
  endtask

  task automatic test_random_packets();
    logic [7:0]  id;
    logic [23:0] value;
    int          waits;
    repeat (20) begin
      id    = 8'(($random(seed) & 3) + 1);  // ids 1 to 4 where 4 matches nobody
      value = 24'($random(seed));
      send_packet(id, value, waits);
      wait_idle();
      check_nodes("random packet");
    end
  endtask

  task automatic test_bad_address();
    logic [31:0] rd;
    logic [1:0]  r;
    int          waits;
    axil_write(8'h0C, 32'h03FFFFFF, r, waits);
    check_eq(32'(r), 32'(resp_slverr), "bresp of write to 0xC");
    axil_read(addr_status, rd, r);
    check_eq(rd, 32'd0, "status after write to 0xC");  // no send started
    axil_read(8'h0C, rd, r);
    check_eq(32'(r), 32'(resp_slverr), "rresp of read from 0xC");
    check_eq(rd, 32'd0, "rdata of read from 0xC");
    repeat (40) @(posedge clk);  // give a stray frame time to land
    #1;
    check_nodes("after accesses to 0xC");
  endtask

  initial begin
    clk      = 1'b0;
    arst_n   = 1'b1;
    axil_req = '0;
    seed     = 80;
    exp_a    = 8'h5A;
    exp_b    = 16'h1234;
    exp_c    = 24'h0;
    #1;
    arst_n = 1'b0;  // falling edge so every register resets
    repeat (16) @(posedge clk);
    #1;
    arst_n = 1'b1;
    test_reset_values();
    test_each_node();
    test_unmatched_id();
    test_back_to_back();
    test_random_packets();
    test_bad_address();
    chk_fails = DUT.node_a.node_chk.fail_cnt + DUT.node_b.node_chk.fail_cnt +
                DUT.node_c.node_chk.fail_cnt;
    if (chk_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: src.f
logic/cfg_pkg.sv
logic/cfg_axil_regs.sv
logic/cfg_ctrl_fsm.sv
logic/cfg_bit_counter.sv
logic/cfg_serializer.sv
logic/config_node.sv
logic/cfg_top.sv
bench/config_node_bind_assert.sv
bench/cfg_tb.sv

// File: Makefile
TOP = cfg_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f src.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f src.f
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^Test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
